// ==== mmb_arbitrator.sv ====
`timescale 1ns/1ps
`default_nettype none
// ----------------------------------------------------------------------
// Multi-master burst arbiter and switch
// ----------------------------------------------------------------------

module mmb_arbitrator #(
    parameter int unsigned          AWIDTH  = mmb_pkg::MMB_AWIDTH,
    parameter int unsigned          DWIDTH  = mmb_pkg::MMB_DWIDTH,
    parameter int unsigned          BWIDTH  = mmb_pkg::MMB_BWIDTH,
    parameter int unsigned          MASTERS = mmb_pkg::MMB_MASTERS,  // 2 or more
    parameter int unsigned          RDPENDS = mmb_pkg::MMB_RDPENDS,  // 2 or more
    parameter mmb_pkg::arb_scheme_e SCHEME  = mmb_pkg::ARB_RR
) (
    input  wire                              i_clk,
    input  wire                              i_rst_n,
    // Master-facing ports
    input  wire  [MASTERS-1:0][AWIDTH-1:0]   i_s_addr,
    input  wire  [MASTERS-1:0][BWIDTH-1:0]   i_s_bcnt,
    input  wire  [MASTERS-1:0]               i_s_wreq,
    input  wire  [MASTERS-1:0][DWIDTH-1:0]   i_s_wdat,
    input  wire  [MASTERS-1:0]               i_s_rreq,
    output logic [MASTERS-1:0][DWIDTH-1:0]   o_s_rdat,
    output logic [MASTERS-1:0]               o_s_rval,
    output logic [MASTERS-1:0]               o_s_busy,
    // Slave-facing port
    output logic [AWIDTH-1:0]                o_m_addr,
    output logic [BWIDTH-1:0]                o_m_bcnt,
    output logic                             o_m_wreq,
    output logic [DWIDTH-1:0]                o_m_wdat,
    output logic                             o_m_rreq,
    input  wire  [DWIDTH-1:0]                i_m_rdat,
    input  wire                              i_m_rval,
    input  wire                              i_m_busy
);
    localparam int unsigned FW = MASTERS + BWIDTH;  // Route entry {grant, bcnt}

    logic [MASTERS-1:0] req;
    logic [MASTERS-1:0] grant;
    logic [MASTERS-1:0] head_gnt;           // Owner of words now returning
    logic [BWIDTH-1:0]  head_bcnt;
    logic [BWIDTH-1:0]  beat_cnt;           // Words seen for head read
    logic [FW-1:0]      head_dat;
    logic               rd_sel;             // Granted port wants a read
    logic               fifo_rdy;           // Room for another read
    logic               fifo_val;
    logic               rd_last;            // Final word of head read

    assign req    = i_s_wreq | i_s_rreq;
    assign rd_sel = |(i_s_rreq & grant);

    // ------------------------------------------------------------------
    // Grant
    mmb_req_arbiter #(
        .REQS   (MASTERS),
        .SCHEME (SCHEME)
    ) u_req_arb (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_req   (req),
        .i_rdy   (~i_m_busy & (~rd_sel | fifo_rdy)),
        .o_gnt   (grant)
    );

    // Stall anyone without grant, plus reads with no route slot
    assign o_s_busy = ~grant | {MASTERS{i_m_busy}} | (i_s_rreq & ~{MASTERS{fifo_rdy}});

    assign o_m_wreq = |(i_s_wreq & grant);
    assign o_m_rreq = rd_sel & fifo_rdy;

    // ------------------------------------------------------------------
    // AND-OR switch of address, bcnt and write data
    always_comb begin
        o_m_addr = '0;
        o_m_bcnt = '0;
        o_m_wdat = '0;
        for (int j = 0; j < MASTERS; j++) begin
            o_m_addr |= i_s_addr[j] & {AWIDTH{grant[j]}};
            o_m_bcnt |= i_s_bcnt[j] & {BWIDTH{grant[j]}};
            o_m_wdat |= i_s_wdat[j] & {DWIDTH{grant[j]}};
        end
    end

    // ------------------------------------------------------------------
    // Read return routing
    mmb_route_fifo #(
        .WIDTH (FW),
        .DEPTH (RDPENDS)
    ) u_route_fifo (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_dat   ({grant, o_m_bcnt}),
        .i_val   (o_m_rreq & ~i_m_busy),    // Accepted read command
        .o_rdy   (fifo_rdy),
        .o_dat   (head_dat),
        .o_val   (fifo_val),
        .i_rdy   (rd_last)                  // Retire after last word
    );

    assign head_gnt  = head_dat[FW-1:BWIDTH];
    assign head_bcnt = head_dat[BWIDTH-1:0];
    assign rd_last   = i_m_rval & (beat_cnt == head_bcnt);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            beat_cnt <= '0;
        end else if (i_m_rval && fifo_val) begin
            beat_cnt <= rd_last ? '0 : beat_cnt + 1'b1;
        end
    end

    assign o_s_rdat = {MASTERS{i_m_rdat}};  // Same data to all
    assign o_s_rval = head_gnt & {MASTERS{fifo_val & i_m_rval}};

endmodule : mmb_arbitrator

`default_nettype wire

// ==== mmb_burst_ram.sv ====
`timescale 1ns/1ps
`default_nettype none
// ----------------------------------------------------------------------
// Burst RAM slave
// ----------------------------------------------------------------------

module mmb_burst_ram #(
    parameter int unsigned AWIDTH = mmb_pkg::MMB_AWIDTH,
    parameter int unsigned DWIDTH = mmb_pkg::MMB_DWIDTH,
    parameter int unsigned BWIDTH = mmb_pkg::MMB_BWIDTH
) (
    input  wire               i_clk,
    input  wire               i_rst_n,
    input  wire  [AWIDTH-1:0] i_addr,
    input  wire  [BWIDTH-1:0] i_bcnt,
    input  wire               i_wreq,
    input  wire  [DWIDTH-1:0] i_wdat,
    input  wire               i_rreq,
    output logic [DWIDTH-1:0] o_rdat,
    output logic              o_rval,
    output logic              o_busy
);
    import mmb_pkg::*;

    localparam int unsigned WORDS = 2 ** AWIDTH;

    logic [DWIDTH-1:0] mem [WORDS];
    ram_state_e        state;

    // Write side
    logic [AWIDTH-1:0] wr_base;             // Beat 0 address
    logic [BWIDTH-1:0] wr_cnt;              // Next beat index
    logic [AWIDTH-1:0] wr_addr;
    logic              wr_fire;

    // Two-entry read command queue
    logic [AWIDTH-1:0] q_addr [2];
    logic [BWIDTH-1:0] q_bcnt [2];
    logic              q_wp;
    logic              q_rp;
    logic [1:0]        q_cnt;
    logic              q_full;
    logic              q_push;
    logic              q_pop;

    // Read stream
    logic [AWIDTH-1:0] rd_base;
    logic [BWIDTH-1:0] rd_cnt;
    logic [BWIDTH-1:0] rd_last;             // bcnt of active read
    logic [AWIDTH-1:0] rd_addr;
    logic              rd_fire;             // Word fetched this cycle

    assign q_full = (q_cnt == 2'd2);
    assign q_pop  = (state == RAM_IDLE) && (q_cnt != 2'd0);    // Start of a read
    assign q_push = i_rreq & ~q_full;

    // Writes wait while reads are queued or streaming, keeping order
    assign o_busy  = (i_rreq & q_full) | (i_wreq & ((state == RAM_READ) | q_pop));
    assign wr_fire = i_wreq & ~o_busy;
    assign wr_addr = (state == RAM_WRITE) ? wr_base + AWIDTH'(wr_cnt) : i_addr;

    assign rd_fire = q_pop | (state == RAM_READ);
    assign rd_addr = (state == RAM_READ) ? rd_base + AWIDTH'(rd_cnt) : q_addr[q_rp];

    // ------------------------------------------------------------------
    // Array, write and read never in the same cycle
    always_ff @(posedge i_clk) begin
        if (wr_fire) begin
            mem[wr_addr] <= i_wdat;
        end
        if (rd_fire) begin
            o_rdat <= mem[rd_addr];
        end
    end

    // ------------------------------------------------------------------
    // Command queue
    always_ff @(posedge i_clk) begin
        if (q_push) begin
            q_addr[q_wp] <= i_addr;
            q_bcnt[q_wp] <= i_bcnt;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            q_wp  <= 1'b0;
            q_rp  <= 1'b0;
            q_cnt <= 2'd0;
        end else begin
            if (q_push) q_wp <= ~q_wp;
            if (q_pop)  q_rp <= ~q_rp;
            q_cnt <= q_cnt + 2'(q_push) - 2'(q_pop);
        end
    end

    // Burst bases, loaded from IDLE
    always_ff @(posedge i_clk) begin
        if (q_pop) begin
            rd_base <= q_addr[q_rp];
            rd_last <= q_bcnt[q_rp];
        end
        if (state == RAM_IDLE && wr_fire) begin
            wr_base <= i_addr;
        end
    end

    // ------------------------------------------------------------------
    // FSM
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state  <= RAM_IDLE;
            o_rval <= 1'b0;
            wr_cnt <= '0;
            rd_cnt <= '0;
        end else begin
            o_rval <= rd_fire;                  // Word lands next cycle
            case (state)
                RAM_IDLE: begin
                    if (q_pop) begin            // First word already fetched
                        rd_cnt <= BWIDTH'(1);
                        if (q_bcnt[q_rp] != '0) state <= RAM_READ;
                    end else if (wr_fire) begin // Beat 0 written at i_addr
                        wr_cnt <= BWIDTH'(1);
                        if (i_bcnt != '0) state <= RAM_WRITE;
                    end
                end
                RAM_WRITE: begin
                    if (wr_fire) begin
                        wr_cnt <= wr_cnt + 1'b1;
                        if (wr_cnt == i_bcnt) state <= RAM_IDLE;   // bcnt held by master
                    end
                end
                RAM_READ: begin
                    rd_cnt <= rd_cnt + 1'b1;
                    if (rd_cnt == rd_last) state <= RAM_IDLE;
                end
                default: state <= RAM_IDLE;
            endcase
        end
    end

endmodule : mmb_burst_ram

`default_nettype wire

// ==== mmb_pkg.sv ====
`default_nettype none
// ----------------------------------------------------------------------
// MMB subsystem shared definitions
// ----------------------------------------------------------------------

package mmb_pkg;

    // ------------------------------------------------------------------
    // Default bus geometry
    localparam int unsigned MMB_AWIDTH  = 8;    // Word address bits
    localparam int unsigned MMB_DWIDTH  = 16;   // Data word bits
    localparam int unsigned MMB_BWIDTH  = 3;    // Burst count, up to 8 words
    localparam int unsigned MMB_MASTERS = 3;    // Request ports
    localparam int unsigned MMB_RDPENDS = 4;    // Reads in flight

    // Bus vectors at default widths
    typedef logic [MMB_AWIDTH-1:0] mmb_addr_t;
    typedef logic [MMB_DWIDTH-1:0] mmb_data_t;
    typedef logic [MMB_BWIDTH-1:0] mmb_bcnt_t;

    // Arbitration scheme
    typedef enum logic {
        ARB_RR,                                 // Round-robin
        ARB_FP                                  // Fixed priority, port 0 highest
    } arb_scheme_e;

    // RAM slave FSM
    typedef enum logic [1:0] {
        RAM_IDLE,
        RAM_WRITE,                              // Mid write burst
        RAM_READ                                // Streaming read words
    } ram_state_e;

endpackage : mmb_pkg

`default_nettype wire

// ==== mmb_req_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none
// ----------------------------------------------------------------------
// Request arbiter with grant lock
// ----------------------------------------------------------------------

module mmb_req_arbiter #(
    parameter int unsigned          REQS   = mmb_pkg::MMB_MASTERS,  // Requesters, 2 or more
    parameter mmb_pkg::arb_scheme_e SCHEME = mmb_pkg::ARB_RR
) (
    input  wire              i_clk,
    input  wire              i_rst_n,
    input  wire  [REQS-1:0]  i_req,     // Request vector
    input  wire              i_rdy,     // Slave can take a beat
    output logic [REQS-1:0]  o_gnt      // One-hot grant
);
    import mmb_pkg::*;

    logic [REQS-1:0] gnt_q;             // Last committed grant
    logic [REQS-1:0] ptr_q;             // One-hot RR start position
    logic [REQS-1:0] req_hi;            // Requests at or above pointer
    logic [REQS-1:0] pick;              // Fresh winner
    logic            lock;

    // Holder keeps the bus while its request stays up
    assign lock   = |(gnt_q & i_req);
    assign req_hi = i_req & ~(ptr_q - 1'b1);

    // ------------------------------------------------------------------
    // Winner selection, lowest set bit of the eligible set
    always_comb begin
        if (SCHEME == ARB_FP) begin
            pick = i_req & (~i_req + 1'b1);         // Port 0 first
        end else if (|req_hi) begin
            pick = req_hi & (~req_hi + 1'b1);       // From pointer upward
        end else begin
            pick = i_req & (~i_req + 1'b1);         // Wrap to bottom
        end
    end

    assign o_gnt = lock ? gnt_q : pick;

    // ------------------------------------------------------------------
    // Commit grant and move pointer past a released winner
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            gnt_q <= '0;
            ptr_q <= REQS'(1);
        end else if (i_rdy) begin
            gnt_q <= o_gnt;
            if (|gnt_q && !lock) begin
                // Rotate so the port after the old holder leads
                ptr_q <= {gnt_q[REQS-2:0], gnt_q[REQS-1]};
            end
        end
    end

endmodule : mmb_req_arbiter

`default_nettype wire

// ==== mmb_route_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none
// ----------------------------------------------------------------------
// Read routing FIFO
// ----------------------------------------------------------------------

module mmb_route_fifo #(
    parameter int unsigned WIDTH = 8,           // Entry width
    parameter int unsigned DEPTH = 4            // Entries, 2 or more
) (
    input  wire              i_clk,
    input  wire              i_rst_n,
    // Push side
    input  wire  [WIDTH-1:0] i_dat,
    input  wire              i_val,
    output logic             o_rdy,             // Not full
    // Pop side, first word fall-through
    output logic [WIDTH-1:0] o_dat,
    output logic             o_val,             // Not empty
    input  wire              i_rdy
);
    localparam int unsigned PW = $clog2(DEPTH);
    localparam int unsigned CW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PW-1:0]    wr_ptr;
    logic [PW-1:0]    rd_ptr;
    logic [CW-1:0]    count;                    // Occupancy
    logic             push;
    logic             pop;

    assign o_rdy = (count != CW'(DEPTH));
    assign o_val = (count != '0);
    assign o_dat = mem[rd_ptr];                 // Head visible with o_val

    assign push = i_val & o_rdy;
    assign pop  = o_val & i_rdy;

    // ------------------------------------------------------------------
    // Storage
    always_ff @(posedge i_clk) begin
        if (push) begin
            mem[wr_ptr] <= i_dat;
        end
    end

    // ------------------------------------------------------------------
    // Pointers and count
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CW'(push) - CW'(pop);  // Both may happen at once
        end
    end

endmodule : mmb_route_fifo

`default_nettype wire

// ==== mmb_subsystem.f ====
mmb_pkg.sv
mmb_req_arbiter.sv
mmb_route_fifo.sv
mmb_arbitrator.sv
mmb_burst_ram.sv
mmb_subsystem_top.sv
tb_mmb_checker.sv
tb_mmb_top.sv

// ==== mmb_subsystem_top.sv ====
`timescale 1ns/1ps
`default_nettype none
// ----------------------------------------------------------------------
// MMB subsystem top
// ----------------------------------------------------------------------

module mmb_subsystem_top #(
    parameter int unsigned          AWIDTH  = mmb_pkg::MMB_AWIDTH,
    parameter int unsigned          DWIDTH  = mmb_pkg::MMB_DWIDTH,
    parameter int unsigned          BWIDTH  = mmb_pkg::MMB_BWIDTH,
    parameter int unsigned          MASTERS = mmb_pkg::MMB_MASTERS,
    parameter int unsigned          RDPENDS = mmb_pkg::MMB_RDPENDS,
    parameter mmb_pkg::arb_scheme_e SCHEME  = mmb_pkg::ARB_RR
) (
    input  wire                              i_clk,
    input  wire                              i_rst_n,
    input  wire  [MASTERS-1:0][AWIDTH-1:0]   i_s_addr,
    input  wire  [MASTERS-1:0][BWIDTH-1:0]   i_s_bcnt,
    input  wire  [MASTERS-1:0]               i_s_wreq,
    input  wire  [MASTERS-1:0][DWIDTH-1:0]   i_s_wdat,
    input  wire  [MASTERS-1:0]               i_s_rreq,
    output logic [MASTERS-1:0][DWIDTH-1:0]   o_s_rdat,
    output logic [MASTERS-1:0]               o_s_rval,
    output logic [MASTERS-1:0]               o_s_busy
);
    // Arbiter to RAM
    logic [AWIDTH-1:0] m_addr;
    logic [BWIDTH-1:0] m_bcnt;
    logic              m_wreq;
    logic [DWIDTH-1:0] m_wdat;
    logic              m_rreq;
    logic [DWIDTH-1:0] m_rdat;
    logic              m_rval;
    logic              m_busy;

    mmb_arbitrator #(
        .AWIDTH  (AWIDTH),
        .DWIDTH  (DWIDTH),
        .BWIDTH  (BWIDTH),
        .MASTERS (MASTERS),
        .RDPENDS (RDPENDS),
        .SCHEME  (SCHEME)
    ) u_arb (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_s_addr (i_s_addr),
        .i_s_bcnt (i_s_bcnt),
        .i_s_wreq (i_s_wreq),
        .i_s_wdat (i_s_wdat),
        .i_s_rreq (i_s_rreq),
        .o_s_rdat (o_s_rdat),
        .o_s_rval (o_s_rval),
        .o_s_busy (o_s_busy),
        .o_m_addr (m_addr),
        .o_m_bcnt (m_bcnt),
        .o_m_wreq (m_wreq),
        .o_m_wdat (m_wdat),
        .o_m_rreq (m_rreq),
        .i_m_rdat (m_rdat),
        .i_m_rval (m_rval),
        .i_m_busy (m_busy)
    );

    mmb_burst_ram #(
        .AWIDTH (AWIDTH),
        .DWIDTH (DWIDTH),
        .BWIDTH (BWIDTH)
    ) u_ram (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_addr  (m_addr),
        .i_bcnt  (m_bcnt),
        .i_wreq  (m_wreq),
        .i_wdat  (m_wdat),
        .i_rreq  (m_rreq),
        .o_rdat  (m_rdat),
        .o_rval  (m_rval),
        .o_busy  (m_busy)
    );

endmodule : mmb_subsystem_top

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the MMB subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_mmb_top
LOG=sim.log

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
    --top-module "$TOP" -f mmb_subsystem.f -o "V$TOP" --Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -qx "Simulation PASSED" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1

// ==== tb_mmb_checker.sv ====
`timescale 1ns/1ps
`default_nettype none
// ----------------------------------------------------------------------
// MMB read data checker
// ----------------------------------------------------------------------

module tb_mmb_checker #(
    parameter int unsigned MASTERS = mmb_pkg::MMB_MASTERS
) (
    input  wire                                         i_clk,
    input  wire                                         i_rst_n,
    input  wire  [MASTERS-1:0][mmb_pkg::MMB_AWIDTH-1:0] i_s_addr,
    input  wire  [MASTERS-1:0][mmb_pkg::MMB_BWIDTH-1:0] i_s_bcnt,
    input  wire  [MASTERS-1:0]                          i_s_wreq,
    input  wire  [MASTERS-1:0][mmb_pkg::MMB_DWIDTH-1:0] i_s_wdat,
    input  wire  [MASTERS-1:0]                          i_s_rreq,
    input  wire  [MASTERS-1:0][mmb_pkg::MMB_DWIDTH-1:0] i_s_rdat,
    input  wire  [MASTERS-1:0]                          i_s_rval,
    input  wire  [MASTERS-1:0]                          i_s_busy,
    output int                                          o_data_errs,
    output int                                          o_seq_errs,
    output int                                          o_words,
    output int                                          o_pending
);
    import mmb_pkg::*;

    mmb_data_t ref_mem [2 ** MMB_AWIDTH];   // Reference memory
    mmb_data_t exp_q   [MASTERS][$];        // Expected words per master
    int        owner_q [$];                 // Owner of each pending word in return order
    int        wr_beat [MASTERS];           // Beat index in current write burst
    int        data_errs = 0;
    int        seq_errs  = 0;
    int        words     = 0;
    int        pend_cnt  = 0;

    assign o_data_errs = data_errs;
    assign o_seq_errs  = seq_errs;
    assign o_words     = words;
    assign o_pending   = pend_cnt;

    // ------------------------------------------------------------------
    // Sample mid-cycle where bus signals are settled
    always @(negedge i_clk) begin : watch
        int        owner;
        mmb_data_t exp_w;

        if ($countones(i_s_rval) > 1) begin
            seq_errs++;
            $display("Read word raised on several masters at once, rval %b at %0t",
                     i_s_rval, $time);
        end

        // Only the one granted requester may see busy low
        if (i_rst_n && ($countones(~i_s_busy) > 1
                        || (~i_s_busy & ~(i_s_wreq | i_s_rreq)) != '0)) begin
            seq_errs++;
            $display("Busy low on an idle master or on several masters, busy %b at %0t",
                     i_s_busy, $time);
        end

        for (int j = 0; j < MASTERS; j++) begin
            if (i_s_rval[j] === 1'b1) begin
                if (owner_q.size() == 0 || exp_q[j].size() == 0) begin
                    seq_errs++;         // Covers rval seen before any read
                    $display("Master %0d got a read word with no read pending at %0t",
                             j, $time);
                end else begin
                    owner = owner_q.pop_front();
                    exp_w = exp_q[j].pop_front();
                    words++;
                    if (owner != j) begin
                        seq_errs++;
                        $display("Fail read_routing: expected master %0d, actual master %0d",
                                 owner, j);
                    end
                    if (i_s_rdat[j] !== exp_w) begin
                        data_errs++;
                        $display("Fail read_data_m%0d: expected %h, actual %h",
                                 j, exp_w, i_s_rdat[j]);
                    end
                end
            end
        end

        // Beat k of a write burst lands at addr+k
        for (int j = 0; j < MASTERS; j++) begin
            if (i_rst_n && i_s_wreq[j] && !i_s_busy[j]) begin
                ref_mem[i_s_addr[j] + mmb_addr_t'(wr_beat[j])] = i_s_wdat[j];
                wr_beat[j] = (wr_beat[j] == int'(i_s_bcnt[j])) ? 0 : wr_beat[j] + 1;
            end
            if (i_rst_n && i_s_rreq[j] && !i_s_busy[j]) begin
                for (int k = 0; k <= int'(i_s_bcnt[j]); k++) begin
                    exp_q[j].push_back(ref_mem[i_s_addr[j] + mmb_addr_t'(k)]);
                    owner_q.push_back(j);
                end
            end
        end
        pend_cnt = owner_q.size();
    end

endmodule : tb_mmb_checker

`default_nettype wire

// ==== tb_mmb_top.sv ====
`timescale 1ns/1ps
`default_nettype none
// ----------------------------------------------------------------------
// MMB subsystem testbench
// ----------------------------------------------------------------------

module tb_mmb_top;
    import mmb_pkg::*;

    localparam int unsigned MASTERS = MMB_MASTERS;
    localparam int unsigned FILLS   = 8;            // 8-word bursts cover a 64-word region
    localparam int unsigned OPS     = FILLS + 40;   // Region fill, then random operations
    localparam int unsigned CLK_NS  = 40;
    localparam int unsigned DRV_NS  = 2;            // Input skew after the rising edge
    localparam longint unsigned TIMEOUT_NS = longint'(OPS) * 8 * 20 * CLK_NS;

    logic                               clk;
    logic                               rst_n;
    wire  [MASTERS-1:0][MMB_AWIDTH-1:0] s_addr;
    wire  [MASTERS-1:0][MMB_BWIDTH-1:0] s_bcnt;
    wire  [MASTERS-1:0]                 s_wreq;
    wire  [MASTERS-1:0][MMB_DWIDTH-1:0] s_wdat;
    wire  [MASTERS-1:0]                 s_rreq;
    wire  [MASTERS-1:0][MMB_DWIDTH-1:0] s_rdat;
    wire  [MASTERS-1:0]                 s_rval;
    wire  [MASTERS-1:0]                 s_busy;
    wire  [MASTERS-1:0]                 mst_fin;    // Master ran all operations
    int                                 data_errs;
    int                                 seq_errs;
    int                                 words;
    int                                 pending;

    // Operation tables, one row per master
    logic        op_wr   [MASTERS][OPS];
    mmb_addr_t   op_addr [MASTERS][OPS];
    mmb_bcnt_t   op_bcnt [MASTERS][OPS];
    mmb_data_t   op_wdat [MASTERS][OPS][8];
    logic [15:0] lfsr_q;

    // Galois LFSR, x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    // Fill data, unique per address
    function automatic mmb_data_t fill_word(input mmb_addr_t a);
        return mmb_data_t'({~a, a});
    endfunction

    mmb_subsystem_top #(
        .AWIDTH  (MMB_AWIDTH),
        .DWIDTH  (MMB_DWIDTH),
        .BWIDTH  (MMB_BWIDTH),
        .MASTERS (MASTERS),
        .RDPENDS (MMB_RDPENDS),
        .SCHEME  (ARB_RR)
    ) uut (
        .i_clk    (clk),
        .i_rst_n  (rst_n),
        .i_s_addr (s_addr),
        .i_s_bcnt (s_bcnt),
        .i_s_wreq (s_wreq),
        .i_s_wdat (s_wdat),
        .i_s_rreq (s_rreq),
        .o_s_rdat (s_rdat),
        .o_s_rval (s_rval),
        .o_s_busy (s_busy)
    );

    tb_mmb_checker #(
        .MASTERS (MASTERS)
    ) u_chk (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_s_addr    (s_addr),
        .i_s_bcnt    (s_bcnt),
        .i_s_wreq    (s_wreq),
        .i_s_wdat    (s_wdat),
        .i_s_rreq    (s_rreq),
        .i_s_rdat    (s_rdat),
        .i_s_rval    (s_rval),
        .i_s_busy    (s_busy),
        .o_data_errs (data_errs),
        .o_seq_errs  (seq_errs),
        .o_words     (words),
        .o_pending   (pending)
    );

    always #(CLK_NS / 2) clk = ~clk;

    // ------------------------------------------------------------------
    // Master drivers
    for (genvar j = 0; j < MASTERS; j++) begin : gen_mst
        mmb_addr_t addr;
        mmb_bcnt_t bcnt;
        mmb_data_t wdat;
        logic      wreq;
        logic      rreq;
        logic      fin;

        assign s_addr[j]  = addr;
        assign s_bcnt[j]  = bcnt;
        assign s_wdat[j]  = wdat;
        assign s_wreq[j]  = wreq;
        assign s_rreq[j]  = rreq;
        assign mst_fin[j] = fin;

        // Hold the beat until a cycle without busy
        task automatic wait_taken();
            @(negedge clk);
            while (s_busy[j]) begin
                @(negedge clk);
            end
            @(posedge clk);
            #(DRV_NS);
        endtask

        initial begin : drive
            addr = '0;
            bcnt = '0;
            wdat = '0;
            wreq = 1'b0;
            rreq = 1'b0;
            fin  = 1'b0;
            wait (rst_n === 1'b1);
            @(posedge clk);
            #(DRV_NS);
            for (int n = 0; n < OPS; n++) begin
                addr = op_addr[j][n];
                bcnt = op_bcnt[j][n];
                if (op_wr[j][n]) begin
                    wreq = 1'b1;                    // Held for the whole burst
                    for (int k = 0; k <= int'(op_bcnt[j][n]); k++) begin
                        wdat = op_wdat[j][n][k];
                        wait_taken();
                    end
                    wreq = 1'b0;
                end else begin
                    rreq = 1'b1;                    // Single command beat
                    wait_taken();
                    rreq = 1'b0;
                end
                @(posedge clk);                     // Idle cycle frees the grant
                #(DRV_NS);
            end
            fin = 1'b1;
        end
    end

    // ------------------------------------------------------------------
    // Tables, reset, end of run
    initial begin : main
        logic [31:0] r;
        logic [5:0]  off;

        clk    = 1'b0;
        rst_n  = 1'b0;
        lfsr_q = 16'd39656;
        for (int j = 0; j < MASTERS; j++) begin
            for (int n = 0; n < OPS; n++) begin
                if (n < FILLS) begin
                    op_wr[j][n]   = 1'b1;
                    op_bcnt[j][n] = '1;
                    op_addr[j][n] = mmb_addr_t'(j * 64 + n * 8);
                end else begin
                    draw_bits(1, r);
                    op_wr[j][n] = r[0];
                    draw_bits(MMB_BWIDTH, r);
                    op_bcnt[j][n] = mmb_bcnt_t'(r);
                    draw_bits(6, r);
                    off = r[5:0];
                    if (int'(off) + int'(op_bcnt[j][n]) > 63) begin
                        off = 6'(63 - int'(op_bcnt[j][n]));   // Stay inside own region
                    end
                    op_addr[j][n] = mmb_addr_t'(j * 64 + int'(off));
                end
                for (int k = 0; k < 8; k++) begin
                    draw_bits(MMB_DWIDTH, r);
                    op_wdat[j][n][k] = (n < FILLS) ? fill_word(op_addr[j][n] + mmb_addr_t'(k))
                                                   : mmb_data_t'(r);
                end
            end
        end

        repeat (8) @(posedge clk);
        #(DRV_NS);
        rst_n = 1'b1;

        wait (&mst_fin);
        wait (pending == 0);
        repeat (16) @(posedge clk);                 // Stray words would show here
        $display("Checked %0d read words, %0d data errors, %0d routing errors",
                 words, data_errs, seq_errs);
        if (data_errs == 0 && seq_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Watchdog expired at %0t, masters finished %b, %0d read words outstanding",
                 $time, mst_fin, pending);
        $display("Simulation FAILED");
        $finish;
    end

endmodule : tb_mmb_top

`default_nettype wire
